/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // datapath widths
    localparam int XLEN   = 64;
    localparam int ILEN   = 32;
    localparam int APB_AW = 32;
    localparam int APB_DW = 32;

    // retire counter width
    localparam int RETIRE_CNT_W = 32;

    // stage register count and stage indices
    localparam int NUM_STAGES = 4;
    localparam int STG_IF_ID  = 0;
    localparam int STG_ID_EX  = 1;
    localparam int STG_EX_MEM = 2;
    localparam int STG_MEM_WB = 3;

    // opcodes seen by predecode
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;

    // token field widths
    localparam int TOK_FLAG_W = 1;
    localparam int TOK_PC_W   = XLEN;
    localparam int TOK_RD_W   = 5;
    localparam int TOK_IMM_W  = XLEN;
    localparam int TOKEN_W    = 4 * TOK_FLAG_W + TOK_PC_W + TOK_RD_W + TOK_IMM_W;

    // token layout, msb to lsb: valid, pc, load, store, jump, rd, imm
    localparam int TOK_IMM_LSB   = 0;
    localparam int TOK_RD_LSB    = TOK_IMM_LSB + TOK_IMM_W;
    localparam int TOK_JUMP_BIT  = TOK_RD_LSB + TOK_RD_W;
    localparam int TOK_STORE_BIT = TOK_JUMP_BIT + TOK_FLAG_W;
    localparam int TOK_LOAD_BIT  = TOK_STORE_BIT + TOK_FLAG_W;
    localparam int TOK_PC_LSB    = TOK_LOAD_BIT + TOK_FLAG_W;
    localparam int TOK_VALID_BIT = TOK_PC_LSB + TOK_PC_W;

endpackage

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import pipe_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    // from hazard control
    input  wire                 stall_i,
    input  wire                 flush_i,
    input  wire                 jump_en_i,
    input  wire [XLEN-1:0]      jump_addr_i,
    // instruction port
    output logic [XLEN-1:0]     imem_addr_o,
    input  wire [ILEN-1:0]      imem_data_i,
    // predecoded token into if_id
    output logic                tok_valid_o,
    output logic [XLEN-1:0]     tok_pc_o,
    output logic                tok_is_load_o,
    output logic                tok_is_store_o,
    output logic                tok_is_jump_o,
    output logic [TOK_RD_W-1:0] tok_rd_o,
    output logic [XLEN-1:0]     tok_imm_o
);

    logic [XLEN-1:0] pc_q;
    logic [6:0]      opcode;

    // redirect beats stall
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (jump_en_i) begin
            pc_q <= jump_addr_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    assign imem_addr_o = pc_q;
    assign opcode      = imem_data_i[6:0];

    assign tok_valid_o    = ~flush_i;
    assign tok_pc_o       = pc_q;
    assign tok_is_load_o  = (opcode == OPC_LOAD);
    assign tok_is_store_o = (opcode == OPC_STORE);
    assign tok_is_jump_o  = (opcode == OPC_JAL);

    // immediate select by format
    always_comb begin
        case (opcode)
            OPC_STORE: begin
                tok_imm_o = {{(XLEN-12){imem_data_i[31]}}, imem_data_i[31:25],
                             imem_data_i[11:7]};
            end
            OPC_JAL: begin
                tok_imm_o = {{(XLEN-21){imem_data_i[31]}}, imem_data_i[31],
                             imem_data_i[19:12], imem_data_i[20],
                             imem_data_i[30:21], 1'b0};
            end
            // loads and alu ops use the i-type field
            default: begin
                tok_imm_o = {{(XLEN-12){imem_data_i[31]}}, imem_data_i[31:20]};
            end
        endcase
    end

    // stores carry imm bits in the rd slot
    assign tok_rd_o = tok_is_store_o ? '0 : imem_data_i[11:7];

endmodule

`default_nettype wire

/* verilog/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg import pipe_pkg::*; #(
    parameter int W = TOKEN_W
) (
    input  wire          clk_i,
    input  wire          arst_n_i,
    input  wire          stall_i,
    input  wire          flush_i,
    input  wire [W-1:0]  d_i,
    output logic [W-1:0] q_o
);

    // flush wins over stall
    // a bubble is the all-zero token, so valid and the
    // memory and jump flags all drop together
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
        // stall holds the current token
    end

endmodule

`default_nettype wire

/* verilog/hazard_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl import pipe_pkg::*; (
    // from id_ex, the instruction in ex
    input  wire                   ex_valid_i,
    input  wire [XLEN-1:0]        ex_pc_i,
    input  wire [XLEN-1:0]        ex_imm_i,
    input  wire                   ex_is_jump_i,
    input  wire                   ex_is_load_i,
    input  wire                   ex_is_store_i,
    // from ex_mem
    input  wire                   mem_is_load_i,
    input  wire                   mem_is_store_i,
    // from lsu
    input  wire                   busy_i,
    input  wire                   busy_end_i,
    // to fetch
    output logic                  jump_en_o,
    output logic [XLEN-1:0]       jump_addr_o,
    output logic                  pc_stall_o,
    output logic                  pc_flush_o,
    // to the stage registers
    output logic [NUM_STAGES-1:0] stall_o,
    output logic [NUM_STAGES-1:0] flush_o
);

    logic mem_inst;
    logic ex_mem_op;

    // jal resolves in ex, target is pc + j-imm
    assign jump_en_o   = ex_valid_i & ex_is_jump_i;
    assign jump_addr_o = ex_pc_i + ex_imm_i;

    // load or store in ex or mem
    assign ex_mem_op = ex_valid_i & (ex_is_load_i | ex_is_store_i);
    assign mem_inst  = ex_mem_op | mem_is_load_i | mem_is_store_i;

    // flush side
    always_comb begin
        if (jump_en_o) begin
            // squash the two younger slots
            pc_flush_o             = 1'b0;
            flush_o[STG_IF_ID]     = 1'b1;
            flush_o[STG_ID_EX]     = 1'b1;
            flush_o[STG_EX_MEM]    = 1'b0;
            flush_o[STG_MEM_WB]    = 1'b0;
        end else if (busy_i) begin
            // bubbles into ex until the transfer ends
            pc_flush_o             = 1'b0;
            flush_o[STG_IF_ID]     = 1'b0;
            flush_o[STG_ID_EX]     = ~busy_end_i;
            flush_o[STG_EX_MEM]    = 1'b0;
            flush_o[STG_MEM_WB]    = 1'b0;
        end else if (mem_inst) begin
            pc_flush_o             = 1'b0;
            flush_o[STG_IF_ID]     = 1'b0;
            flush_o[STG_ID_EX]     = 1'b1;
            flush_o[STG_EX_MEM]    = 1'b0;
            flush_o[STG_MEM_WB]    = 1'b0;
        end else begin
            pc_flush_o             = 1'b0;
            flush_o[STG_IF_ID]     = 1'b0;
            flush_o[STG_ID_EX]     = 1'b0;
            flush_o[STG_EX_MEM]    = 1'b0;
            flush_o[STG_MEM_WB]    = 1'b0;
        end
    end

    // stall side, no entry for a jump
    always_comb begin
        if (busy_i) begin
            // hold front end and mem, release on the busy-end cycle
            pc_stall_o             = ~busy_end_i;
            stall_o[STG_IF_ID]     = ~busy_end_i;
            stall_o[STG_ID_EX]     = 1'b0;
            stall_o[STG_EX_MEM]    = ~busy_end_i;
            stall_o[STG_MEM_WB]    = 1'b0;
        end else if (mem_inst) begin
            // mem op about to enter mem
            pc_stall_o             = 1'b1;
            stall_o[STG_IF_ID]     = 1'b1;
            stall_o[STG_ID_EX]     = 1'b0;
            stall_o[STG_EX_MEM]    = 1'b0;
            stall_o[STG_MEM_WB]    = 1'b0;
        end else begin
            pc_stall_o             = 1'b0;
            stall_o[STG_IF_ID]     = 1'b0;
            stall_o[STG_ID_EX]     = 1'b0;
            stall_o[STG_EX_MEM]    = 1'b0;
            stall_o[STG_MEM_WB]    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_apb import pipe_pkg::*; (
    input  wire               clk_i,
    input  wire               arst_n_i,
    // token in ex_mem
    input  wire               mem_valid_i,
    input  wire               mem_is_load_i,
    input  wire               mem_is_store_i,
    input  wire [XLEN-1:0]    mem_pc_i,
    input  wire [XLEN-1:0]    mem_imm_i,
    // apb master
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    output logic [APB_AW-1:0] paddr_o,
    output logic [APB_DW-1:0] pwdata_o,
    input  wire [APB_DW-1:0]  prdata_i,
    input  wire               pready_i,
    // to hazard control
    output logic              busy_o,
    output logic              busy_end_o,
    // to retire
    output logic [APB_DW-1:0] load_data_o
);

    logic access_q;
    logic mem_op;
    logic [APB_DW-1:0] load_data_q;

    // a valid load or store sitting in mem
    assign mem_op = mem_valid_i & (mem_is_load_i | mem_is_store_i);

    // setup phase is psel with access_q low
    assign psel_o    = mem_op;
    assign penable_o = access_q;

    // address from x0 + imm
    assign paddr_o  = mem_imm_i[APB_AW-1:0];
    // store data stands in with the store's own pc
    assign pwdata_o = mem_pc_i[APB_DW-1:0];
    assign pwrite_o = mem_is_store_i;

    // completing access
    assign busy_end_o = psel_o & penable_o & pready_i;
    // busy spans setup through the completing cycle
    assign busy_o     = psel_o;

    // setup -> access, back to idle on pready
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            access_q <= 1'b0;
        end else if (busy_end_o) begin
            access_q <= 1'b0;
        end else if (psel_o) begin
            access_q <= 1'b1;
        end
    end

    // last load result
    always_ff @(posedge clk_i) begin
        if (busy_end_o && mem_is_load_i) begin
            load_data_q <= prdata_i;
        end
    end

    assign load_data_o = load_data_q;

endmodule

`default_nettype wire

/* verilog/wb_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_retire import pipe_pkg::*; (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    // token in mem_wb
    input  wire                     wb_valid_i,
    input  wire [XLEN-1:0]          wb_pc_i,
    input  wire [TOK_RD_W-1:0]      wb_rd_i,
    input  wire                     wb_is_load_i,
    // captured at the load's busy-end edge
    input  wire [APB_DW-1:0]        load_data_i,
    // retire report
    output logic                    retire_valid_o,
    output logic [XLEN-1:0]         retire_pc_o,
    output logic [TOK_RD_W-1:0]     retire_rd_o,
    output logic [APB_DW-1:0]       retire_data_o,
    output logic [RETIRE_CNT_W-1:0] retire_count_o
);

    logic [RETIRE_CNT_W-1:0] count_q;

    // mem_wb is already a register, report straight from it
    assign retire_valid_o = wb_valid_i;
    assign retire_pc_o    = wb_pc_i;
    assign retire_rd_o    = wb_rd_i;
    // only loads carry data
    assign retire_data_o  = (wb_valid_i && wb_is_load_i) ? load_data_i : '0;

    // minstret style count
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (wb_valid_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign retire_count_o = count_q;

endmodule

`default_nettype wire

/* verilog/pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_top import pipe_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    // instruction port
    output logic [XLEN-1:0]         imem_addr_o,
    input  wire [ILEN-1:0]          imem_data_i,
    // apb master
    output logic                    psel_o,
    output logic                    penable_o,
    output logic                    pwrite_o,
    output logic [APB_AW-1:0]       paddr_o,
    output logic [APB_DW-1:0]       pwdata_o,
    input  wire [APB_DW-1:0]        prdata_i,
    input  wire                     pready_i,
    // retire port
    output logic                    retire_valid_o,
    output logic [XLEN-1:0]         retire_pc_o,
    output logic [TOK_RD_W-1:0]     retire_rd_o,
    output logic [APB_DW-1:0]       retire_data_o,
    output logic [RETIRE_CNT_W-1:0] retire_count_o
);

    // fetch token
    logic                f_valid, f_is_load, f_is_store, f_is_jump;
    logic [XLEN-1:0]     f_pc, f_imm;
    logic [TOK_RD_W-1:0] f_rd;
    // control
    logic                  jump_en, pc_stall, pc_flush, busy, busy_end;
    logic [XLEN-1:0]       jump_addr;
    logic [NUM_STAGES-1:0] stall, flush;
    logic [APB_DW-1:0]     load_data;
    // stage chain
    logic [TOKEN_W-1:0] stage_d [NUM_STAGES];
    logic [TOKEN_W-1:0] stage_q [NUM_STAGES];

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(pc_stall), .flush_i(pc_flush),
        .jump_en_i(jump_en), .jump_addr_i(jump_addr),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .tok_valid_o(f_valid), .tok_pc_o(f_pc), .tok_is_load_o(f_is_load),
        .tok_is_store_o(f_is_store), .tok_is_jump_o(f_is_jump),
        .tok_rd_o(f_rd), .tok_imm_o(f_imm)
    );

    // pack in layout order, valid at the msb
    assign stage_d[STG_IF_ID] = {f_valid, f_pc, f_is_load, f_is_store, f_is_jump, f_rd, f_imm};

    // if_id, id_ex, ex_mem, mem_wb
    for (genvar gi = 0; gi < NUM_STAGES; gi++) begin : g_stage
        if (gi > 0) begin : g_chain
            // a held stage passes a bubble downstream
            assign stage_d[gi] = stall[gi-1] ? '0 : stage_q[gi-1];
        end
        stage_reg #(.W(TOKEN_W)) u_stage (
            .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall[gi]), .flush_i(flush[gi]),
            .d_i(stage_d[gi]), .q_o(stage_q[gi])
        );
    end

    hazard_ctrl u_ctrl (
        .ex_valid_i(stage_q[STG_ID_EX][TOK_VALID_BIT]),
        .ex_pc_i(stage_q[STG_ID_EX][TOK_PC_LSB +: XLEN]),
        .ex_imm_i(stage_q[STG_ID_EX][TOK_IMM_LSB +: XLEN]),
        .ex_is_jump_i(stage_q[STG_ID_EX][TOK_JUMP_BIT]),
        .ex_is_load_i(stage_q[STG_ID_EX][TOK_LOAD_BIT]),
        .ex_is_store_i(stage_q[STG_ID_EX][TOK_STORE_BIT]),
        .mem_is_load_i(stage_q[STG_EX_MEM][TOK_LOAD_BIT]),
        .mem_is_store_i(stage_q[STG_EX_MEM][TOK_STORE_BIT]),
        .busy_i(busy), .busy_end_i(busy_end),
        .jump_en_o(jump_en), .jump_addr_o(jump_addr),
        .pc_stall_o(pc_stall), .pc_flush_o(pc_flush), .stall_o(stall), .flush_o(flush)
    );

    lsu_apb u_lsu (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .mem_valid_i(stage_q[STG_EX_MEM][TOK_VALID_BIT]),
        .mem_is_load_i(stage_q[STG_EX_MEM][TOK_LOAD_BIT]),
        .mem_is_store_i(stage_q[STG_EX_MEM][TOK_STORE_BIT]),
        .mem_pc_i(stage_q[STG_EX_MEM][TOK_PC_LSB +: XLEN]),
        .mem_imm_i(stage_q[STG_EX_MEM][TOK_IMM_LSB +: XLEN]),
        .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o), .paddr_o(paddr_o),
        .pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i),
        .busy_o(busy), .busy_end_o(busy_end), .load_data_o(load_data)
    );

    wb_retire u_retire (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .wb_valid_i(stage_q[STG_MEM_WB][TOK_VALID_BIT]),
        .wb_pc_i(stage_q[STG_MEM_WB][TOK_PC_LSB +: XLEN]),
        .wb_rd_i(stage_q[STG_MEM_WB][TOK_RD_LSB +: TOK_RD_W]),
        .wb_is_load_i(stage_q[STG_MEM_WB][TOK_LOAD_BIT]), .load_data_i(load_data),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .retire_count_o(retire_count_o)
    );

endmodule

`default_nettype wire

/* tests/apb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model #(
    parameter logic [31:0] SEED = 32'd12
) (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         psel_i,
    input  wire         penable_i,
    input  wire         pwrite_i,
    input  wire  [31:0] paddr_i,
    input  wire  [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o
);

    // word memory, indexed by paddr[11:2]
    logic [31:0] mem [0:1023];
    logic [31:0] lcg_q;
    logic [31:0] lcg_nxt;
    logic [1:0]  wait_q;
    // one log entry per completed transfer
    logic [31:0] log_addr [0:63];
    logic [31:0] log_wdata [0:63];
    logic        log_write [0:63];
    int          log_count = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign lcg_nxt  = lcg_next(lcg_q);
    assign prdata_o = mem[paddr_i[11:2]];
    assign pready_o = psel_i & penable_i & (wait_q == 2'd0);

    // wait states picked in the setup cycle
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lcg_q  <= SEED;
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            lcg_q  <= lcg_nxt;
            wait_q <= lcg_nxt[17:16];
        end else if (psel_i && penable_i && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge clk_i) begin
        if (pready_o) begin
            if (pwrite_i) begin
                mem[paddr_i[11:2]] <= pwdata_i;
            end
            if (log_count < 64) begin
                log_addr[log_count]  <= paddr_i;
                log_wdata[log_count] <= pwdata_i;
                log_write[log_count] <= pwrite_i;
            end
            log_count <= log_count + 1;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_top;

    localparam logic [63:0] RESET_PC = 64'h0000_0000_8000_0000;
    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam int K_ALU = 0, K_LOAD = 1, K_STORE = 2, K_JAL = 3;
    // retirements per test plus memory ops, for the watchdog
    localparam int TOTAL_RETIRES = 10 + 6 + 8 + 7;
    localparam int MEM_OPS = 7;
    localparam int WATCHDOG_CYCLES = TOTAL_RETIRES * 10 + MEM_OPS * 5 + 5 * 8;

    logic        clk, arst_n;
    logic [63:0] imem_addr, imem_off, retire_pc;
    logic [31:0] imem_data, paddr, pwdata, prdata, retire_data, retire_count;
    logic        psel, penable, pwrite, pready, retire_valid;
    logic [4:0]  retire_rd;

    // program image and its decoded view
    logic [31:0] imem [0:255];
    int          p_kind [0:255];
    logic [4:0]  p_rd [0:255];
    logic [63:0] p_imm [0:255];
    int          prog_len;
    // expected retire stream and memory ops
    logic [31:0] shadow [0:1023];
    logic [63:0] exp_pc [0:63];
    logic [4:0]  exp_rd [0:63];
    logic [31:0] exp_data [0:63];
    logic [31:0] op_addr [0:15], op_wdata [0:15];
    logic        op_write [0:15];
    int          op_n, log_base;
    int          retire_cyc [0:63];
    int          mismatch_count = 0;
    int          other_count = 0;

    pipe_top #(.RESET_PC(RESET_PC)) UUT (
        .clk_i(clk), .arst_n_i(arst_n), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr),
        .pwdata_o(pwdata), .prdata_i(prdata), .pready_i(pready),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .retire_count_o(retire_count)
    );

    apb_mem_model #(.SEED(32'd12)) u_mem (
        .clk_i(clk), .arst_n_i(arst_n), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // combinational instruction port, nop outside the image
    always_comb begin
        imem_off  = imem_addr - RESET_PC;
        imem_data = (imem_off < 64'd1024) ? imem[imem_off[9:2]] : NOP;
    end

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9E37_79B9) ^ 32'hC0DE_5A00 ^ {idx[15:0], ~idx[15:0]};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            other_count++;
            $display("error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic clear_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
        end
    endtask

    task automatic emit(input int kind, input logic [4:0] rd, input logic [63:0] imm);
        p_kind[prog_len] = kind;
        p_rd[prog_len]   = rd;
        p_imm[prog_len]  = imm;
        case (kind)
            K_LOAD:  imem[prog_len] = {imm[11:0], 5'd0, 3'b010, rd, 7'h03};
            K_STORE: imem[prog_len] = {imm[11:5], 10'd0, 3'b010, imm[4:0], 7'h23};
            K_JAL:   imem[prog_len] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
            default: imem[prog_len] = {imm[11:0], 5'd0, 3'd0, rd, 7'h13};
        endcase
        prog_len++;
    endtask

    // walk the program from the reset pc, following jal targets
    task automatic build_expected(input int n);
        logic [63:0] pc;
        int i;
        pc   = RESET_PC;
        op_n = 0;
        for (int k = 0; k < n; k++) begin
            i = int'((pc - RESET_PC) >> 2);
            exp_pc[k]   = pc;
            exp_rd[k]   = (p_kind[i] == K_STORE) ? 5'd0 : p_rd[i];
            exp_data[k] = '0;
            if (p_kind[i] == K_LOAD || p_kind[i] == K_STORE) begin
                op_addr[op_n]  = p_imm[i][31:0];
                op_write[op_n] = (p_kind[i] == K_STORE);
                op_wdata[op_n] = pc[31:0];
                op_n++;
            end
            if (p_kind[i] == K_LOAD) begin
                exp_data[k] = shadow[p_imm[i][11:2]];
            end else if (p_kind[i] == K_STORE) begin
                shadow[p_imm[i][11:2]] = pc[31:0];
            end
            pc = (p_kind[i] == K_JAL) ? pc + p_imm[i] : pc + 64'd4;
        end
    endtask

    task automatic apply_reset(input int n);
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            u_mem.mem[i] = fill_word(i);
            shadow[i]    = fill_word(i);
        end
        build_expected(n);
        repeat (3) @(negedge clk);
        arst_n   = 1'b1;
        log_base = u_mem.log_count;
    endtask

    task automatic run_program(input int n);
        int k;
        int cyc;
        apply_reset(n);
        k   = 0;
        cyc = 0;
        while (k < n && cyc < n * 10 + 20) begin
            @(negedge clk);
            cyc++;
            if (retire_valid) begin
                check_val("retire_pc_o", exp_pc[k], retire_pc);
                check_val("retire_rd_o", exp_rd[k], retire_rd);
                check_val("retire_data_o", exp_data[k], retire_data);
                retire_cyc[k] = cyc;
                k++;
            end
        end
        check_true(k == n, "pipeline stopped retiring before the expected count");
        @(negedge clk);
        check_val("retire_count_o", n, retire_count);
        check_val("apb transfer count", op_n, u_mem.log_count - log_base);
        for (int i = 0; i < op_n; i++) begin
            check_val("paddr_o", op_addr[i], u_mem.log_addr[log_base + i]);
            check_val("pwrite_o", op_write[i], u_mem.log_write[log_base + i]);
            if (op_write[i]) begin
                check_val("pwdata_o", op_wdata[i], u_mem.log_wdata[log_base + i]);
                check_val("memory word", shadow[op_addr[i][11:2]],
                          u_mem.mem[op_addr[i][11:2]]);
            end
        end
    endtask

    task automatic test_reset_state();
        clear_program();
        emit(K_JAL, 5'd0, 64'd0);
        apply_reset(0);
        check_val("retire_valid_o", 1'b0, retire_valid);
        check_val("psel_o", 1'b0, psel);
        check_val("penable_o", 1'b0, penable);
        check_val("imem_addr_o", RESET_PC, imem_addr);
    endtask

    task automatic test_straight_line();
        clear_program();
        for (int i = 0; i < 8; i++) begin
            emit(K_ALU, 5'(i + 1), 64'(i * 3));
        end
        emit(K_JAL, 5'd0, 64'd0);
        run_program(10);
        // first retire four cycles after fetch, then one per cycle
        for (int i = 0; i < 8; i++) begin
            check_val("retire cycle", 4 + i, retire_cyc[i]);
        end
    endtask

    task automatic test_jal();
        clear_program();
        emit(K_ALU, 5'd1, 64'd7);
        emit(K_JAL, 5'd5, 64'd16);
        // squashed or jumped over
        emit(K_ALU, 5'd20, 64'd1);
        emit(K_ALU, 5'd21, 64'd2);
        emit(K_ALU, 5'd22, 64'd3);
        emit(K_ALU, 5'd6, 64'd4);
        emit(K_ALU, 5'd7, 64'd5);
        emit(K_JAL, 5'd0, 64'd0);
        run_program(6);
    endtask

    task automatic test_loads();
        clear_program();
        emit(K_ALU, 5'd1, 64'd1);
        emit(K_LOAD, 5'd2, 64'h100);
        emit(K_ALU, 5'd3, 64'd2);
        emit(K_LOAD, 5'd4, 64'h104);
        emit(K_LOAD, 5'd5, 64'h3fc);
        emit(K_ALU, 5'd6, 64'd3);
        emit(K_JAL, 5'd0, 64'd0);
        run_program(8);
    endtask

    task automatic test_stores();
        clear_program();
        emit(K_STORE, 5'd0, 64'h200);
        emit(K_LOAD, 5'd1, 64'h200);
        emit(K_STORE, 5'd0, 64'h204);
        emit(K_LOAD, 5'd2, 64'h204);
        emit(K_ALU, 5'd3, 64'd9);
        emit(K_JAL, 5'd0, 64'd0);
        run_program(7);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count + 1);
        $display("sim failed");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        clear_program();
        test_reset_state();
        test_straight_line();
        test_jal();
        test_loads();
        test_stores();
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/pipe_pkg.sv
verilog/fetch_unit.sv
verilog/stage_reg.sv
verilog/hazard_ctrl.sv
verilog/lsu_apb.sv
verilog/wb_retire.sv
verilog/pipe_top.sv
tests/apb_mem_model.sv
tests/tb_pipe_top.sv
